//--- source/riscv_isa_pkg.sv
// RV32I base encoding only; compressed, 64-bit and extension opcodes are not decodable here
package riscv_isa_pkg;

    // Base widths of the 32-bit encoding
    localparam int unsigned XLEN      = 32;
    localparam int unsigned ILEN      = 32;
    localparam int unsigned REG_IDX_W = 5;
    localparam int unsigned OPCODE_W  = 5;
    localparam int unsigned FUNCT3_W  = 3;
    localparam int unsigned FUNCT7_W  = 7;
    localparam int unsigned FORMAT_W  = 3;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [ILEN-1:0]      instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [FUNCT3_W-1:0]  funct3_t;
    typedef logic [FUNCT7_W-1:0]  funct7_t;

    // Major opcode, instr[6:2]
    // Low two bits are checked separately
    typedef enum logic [OPCODE_W-1:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100
    } opcode_e;

    // Immediate layout of the instruction
    // BAD covers every opcode the stage does not support
    typedef enum logic [FORMAT_W-1:0] {
        INSTR_FORMAT_BAD = 3'b000,
        INSTR_FORMAT_R,
        INSTR_FORMAT_I,
        INSTR_FORMAT_S,
        INSTR_FORMAT_B,
        INSTR_FORMAT_U,
        INSTR_FORMAT_J
    } instr_format_e;

    // Raw decode of one instruction, before control generation
    typedef struct packed {
        opcode_e       opcode;
        instr_format_e format;
        funct3_t       funct3;
        funct7_t       funct7;
        reg_idx_t      rd_idx;
        reg_idx_t      rs1_idx;
        reg_idx_t      rs2_idx;
        // Sign-extended, zero for R and BAD
        word_t         imm;
        // instr[1:0] == 2'b11
        logic          low_bits_ok;
    } fields_s;

endpackage : riscv_isa_pkg

//--- source/decode_ctrl_pkg.sv
// Execute-side control encodings and stage boundary structs; needs riscv_isa_pkg compiled first
package decode_ctrl_pkg;

    // ALU operation, one per RV32I integer op
    typedef enum logic [3:0] {
        ALU_OP_ADD = 4'd0,
        ALU_OP_SUB,
        ALU_OP_SLL,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_XOR,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_OR,
        ALU_OP_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1 = 2'd0,
        ALU_OP1_SRC_PC,
        ALU_OP1_SRC_ZERO
    } alu_op1_src_e;

    // FOUR gives the link address for jumps
    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS2 = 2'd0,
        ALU_OP2_SRC_IMM,
        ALU_OP2_SRC_FOUR
    } alu_op2_src_e;

    // Writeback source
    typedef enum logic {
        RD_SRC_ALU = 1'b0,
        RD_SRC_MEM = 1'b1
    } rd_src_e;

    // 2'b11 is unused
    typedef enum logic [1:0] {
        MEM_OP_NONE  = 2'd0,
        MEM_OP_LOAD,
        MEM_OP_STORE
    } mem_op_e;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'b00,
        MEM_SIZE_HALF = 2'b01,
        MEM_SIZE_WORD = 2'b10
    } mem_size_e;

    typedef enum logic [1:0] {
        BRANCH_NONE = 2'd0,
        BRANCH_JAL,
        BRANCH_JALR,
        BRANCH_COND
    } branch_e;

    // Same bits as funct3 of BRANCH
    typedef enum logic [2:0] {
        CMP_OP_EQ  = 3'b000,
        CMP_OP_NE  = 3'b001,
        CMP_OP_LT  = 3'b100,
        CMP_OP_GE  = 3'b101,
        CMP_OP_LTU = 3'b110,
        CMP_OP_GEU = 3'b111
    } cmp_op_e;

    // Everything the execute stage needs besides operands
    typedef struct packed {
        logic         illegal_instr;
        rd_src_e      rd_src;
        logic         rd_we;
        alu_op1_src_e alu_op1_src;
        alu_op2_src_e alu_op2_src;
        alu_op_e      alu_op;
        mem_op_e      mem_op;
        logic         mem_signed;
        mem_size_e    mem_size;
        branch_e      branch;
        cmp_op_e      cmp_op;
    } ctrl_s;

    typedef struct packed {
        riscv_isa_pkg::word_t  pc;
        riscv_isa_pkg::instr_t instr;
    } fetch_to_decode_s;

    typedef struct packed {
        riscv_isa_pkg::word_t    pc;
        riscv_isa_pkg::reg_idx_t rd_idx;
        riscv_isa_pkg::reg_idx_t rs1_idx;
        riscv_isa_pkg::reg_idx_t rs2_idx;
        riscv_isa_pkg::word_t    rs1_val;
        riscv_isa_pkg::word_t    rs2_val;
        riscv_isa_pkg::word_t    immediate;
        ctrl_s                   ctrl;
    } decode_to_exec_s;

endpackage : decode_ctrl_pkg

//--- source/decode_input_reg.sv
// Expects in_valid low during stall or flush and never both stall and flush; payload has no reset
module decode_input_reg (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              stall,
    input  logic                              flush,
    input  logic                              in_valid,
    input  decode_ctrl_pkg::fetch_to_decode_s in_payload,
    output decode_ctrl_pkg::fetch_to_decode_s payload,
    output logic                              out_valid
);

    logic valid_q;

    // Valid flop, holds under stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;
        end
    end

    // Payload only matters while valid_q is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            payload <= in_payload;
        end
    end

    // Flush kills the held item; the next capture clears valid_q
    assign out_valid = valid_q && !stall && !flush;

    // Hazard unit contract on the inputs
    a_stall_no_input: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !in_valid)
        else $error("decode input valid while stalled");

    a_stall_flush_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(stall && flush))
        else $error("decode stall and flush both high");

    a_out_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid))
        else $error("decode output valid unknown");

endmodule : decode_input_reg

//--- source/instr_field_extract.sv
// Combinational RV32I field split; does not judge legality beyond the format and low-bit check
module instr_field_extract (
    input  riscv_isa_pkg::instr_t   instr,
    output riscv_isa_pkg::fields_s  fields
);

    riscv_isa_pkg::opcode_e       opcode;
    riscv_isa_pkg::instr_format_e format;
    riscv_isa_pkg::word_t         imm;

    // Opcode from bits 6..2, format from opcode
    always_comb begin
        opcode = riscv_isa_pkg::opcode_e'(instr[6:2]);
        unique case (opcode)
            riscv_isa_pkg::OPCODE_OP:
                format = riscv_isa_pkg::INSTR_FORMAT_R;
            riscv_isa_pkg::OPCODE_LOAD,
            riscv_isa_pkg::OPCODE_OP_IMM,
            riscv_isa_pkg::OPCODE_JALR:
                format = riscv_isa_pkg::INSTR_FORMAT_I;
            riscv_isa_pkg::OPCODE_STORE:
                format = riscv_isa_pkg::INSTR_FORMAT_S;
            riscv_isa_pkg::OPCODE_BRANCH:
                format = riscv_isa_pkg::INSTR_FORMAT_B;
            riscv_isa_pkg::OPCODE_LUI,
            riscv_isa_pkg::OPCODE_AUIPC:
                format = riscv_isa_pkg::INSTR_FORMAT_U;
            riscv_isa_pkg::OPCODE_JAL:
                format = riscv_isa_pkg::INSTR_FORMAT_J;
            // SYSTEM, AMO, MISC_MEM and unknown codes
            default:
                format = riscv_isa_pkg::INSTR_FORMAT_BAD;
        endcase
    end

    // Immediate per format, sign bit is always instr[31]
    always_comb begin
        unique case (format)
            riscv_isa_pkg::INSTR_FORMAT_I:
                imm = {{20{instr[31]}}, instr[31:20]};
            riscv_isa_pkg::INSTR_FORMAT_S:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offset, bit 0 implied zero
            riscv_isa_pkg::INSTR_FORMAT_B:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            // Upper 20 bits, low 12 zero
            riscv_isa_pkg::INSTR_FORMAT_U:
                imm = {instr[31:12], 12'h000};
            // Jump offset, bit 0 implied zero
            riscv_isa_pkg::INSTR_FORMAT_J:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            // R and BAD carry no immediate
            default:
                imm = '0;
        endcase
    end

    // Fixed field positions, valid or not for the format
    always_comb begin
        fields.opcode      = opcode;
        fields.format      = format;
        fields.funct3      = instr[14:12];
        fields.funct7      = instr[31:25];
        fields.rd_idx      = instr[11:7];
        fields.rs1_idx     = instr[19:15];
        fields.rs2_idx     = instr[24:20];
        fields.imm         = imm;
        // Anything else is a compressed or reserved encoding
        fields.low_bits_ok = (instr[1:0] == 2'b11);
    end

endmodule : instr_field_extract

//--- source/ctrl_decoder.sv
// RV32I control table only; SYSTEM, AMO and MISC_MEM decode as illegal, funct checks are partial
module ctrl_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid,
    input  riscv_isa_pkg::fields_s  fields,
    output decode_ctrl_pkg::ctrl_s  ctrl
);

    logic                      writes_rd;
    logic                      rd_nonzero;
    decode_ctrl_pkg::alu_op_e  funct_alu_op;

    // x0 writes are dropped here so later stages never forward them
    assign rd_nonzero = (fields.rd_idx != '0);

    // ALU op for OP and OP_IMM by funct3
    // funct7[5] picks SUB on OP only, SRA on both
    always_comb begin
        unique case (fields.funct3)
            3'b000: begin
                if (fields.opcode == riscv_isa_pkg::OPCODE_OP && fields.funct7[5]) begin
                    funct_alu_op = decode_ctrl_pkg::ALU_OP_SUB;
                end else begin
                    funct_alu_op = decode_ctrl_pkg::ALU_OP_ADD;
                end
            end
            3'b001: funct_alu_op = decode_ctrl_pkg::ALU_OP_SLL;
            3'b010: funct_alu_op = decode_ctrl_pkg::ALU_OP_SLT;
            3'b011: funct_alu_op = decode_ctrl_pkg::ALU_OP_SLTU;
            3'b100: funct_alu_op = decode_ctrl_pkg::ALU_OP_XOR;
            3'b101: begin
                funct_alu_op = fields.funct7[5] ? decode_ctrl_pkg::ALU_OP_SRA
                                                : decode_ctrl_pkg::ALU_OP_SRL;
            end
            3'b110: funct_alu_op = decode_ctrl_pkg::ALU_OP_OR;
            default: funct_alu_op = decode_ctrl_pkg::ALU_OP_AND;
        endcase
    end

    // Per-opcode control table
    // Zero fields mean RS1, RS2, ADD, no memory, no branch
    always_comb begin
        ctrl      = '0;
        writes_rd = 1'b0;
        if (!fields.low_bits_ok) begin
            ctrl.illegal_instr = 1'b1;
        end else begin
            unique case (fields.opcode)
                riscv_isa_pkg::OPCODE_OP: begin
                    writes_rd        = 1'b1;
                    ctrl.rd_src      = decode_ctrl_pkg::RD_SRC_ALU;
                    ctrl.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_RS1;
                    ctrl.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_RS2;
                    ctrl.alu_op      = funct_alu_op;
                end
                riscv_isa_pkg::OPCODE_OP_IMM: begin
                    writes_rd        = 1'b1;
                    ctrl.rd_src      = decode_ctrl_pkg::RD_SRC_ALU;
                    ctrl.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_RS1;
                    ctrl.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
                    ctrl.alu_op      = funct_alu_op;
                end
                // Address is rs1 + imm in the ALU
                riscv_isa_pkg::OPCODE_LOAD: begin
                    writes_rd        = 1'b1;
                    ctrl.rd_src      = decode_ctrl_pkg::RD_SRC_MEM;
                    ctrl.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_RS1;
                    ctrl.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
                    ctrl.alu_op      = decode_ctrl_pkg::ALU_OP_ADD;
                    ctrl.mem_op      = decode_ctrl_pkg::MEM_OP_LOAD;
                    // LBU/LHU have funct3[2] set
                    ctrl.mem_signed  = !fields.funct3[2];
                    ctrl.mem_size    = decode_ctrl_pkg::mem_size_e'(fields.funct3[1:0]);
                end
                riscv_isa_pkg::OPCODE_STORE: begin
                    ctrl.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_RS1;
                    ctrl.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
                    ctrl.alu_op      = decode_ctrl_pkg::ALU_OP_ADD;
                    ctrl.mem_op      = decode_ctrl_pkg::MEM_OP_STORE;
                    ctrl.mem_size    = decode_ctrl_pkg::mem_size_e'(fields.funct3[1:0]);
                end
                // Target adder lives in execute, compare op straight from funct3
                riscv_isa_pkg::OPCODE_BRANCH: begin
                    ctrl.branch = decode_ctrl_pkg::BRANCH_COND;
                    ctrl.cmp_op = decode_ctrl_pkg::cmp_op_e'(fields.funct3);
                end
                // Link value pc + 4 through the ALU
                riscv_isa_pkg::OPCODE_JAL,
                riscv_isa_pkg::OPCODE_JALR: begin
                    writes_rd        = 1'b1;
                    ctrl.rd_src      = decode_ctrl_pkg::RD_SRC_ALU;
                    ctrl.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_PC;
                    ctrl.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_FOUR;
                    ctrl.alu_op      = decode_ctrl_pkg::ALU_OP_ADD;
                    if (fields.opcode == riscv_isa_pkg::OPCODE_JAL) begin
                        ctrl.branch = decode_ctrl_pkg::BRANCH_JAL;
                    end else begin
                        ctrl.branch = decode_ctrl_pkg::BRANCH_JALR;
                    end
                end
                riscv_isa_pkg::OPCODE_LUI: begin
                    writes_rd        = 1'b1;
                    ctrl.rd_src      = decode_ctrl_pkg::RD_SRC_ALU;
                    ctrl.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_ZERO;
                    ctrl.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
                    ctrl.alu_op      = decode_ctrl_pkg::ALU_OP_ADD;
                end
                riscv_isa_pkg::OPCODE_AUIPC: begin
                    writes_rd        = 1'b1;
                    ctrl.rd_src      = decode_ctrl_pkg::RD_SRC_ALU;
                    ctrl.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_PC;
                    ctrl.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
                    ctrl.alu_op      = decode_ctrl_pkg::ALU_OP_ADD;
                end
                // SYSTEM, AMO, MISC_MEM and unknown codes
                default: ctrl.illegal_instr = 1'b1;
            endcase
        end
        ctrl.rd_we = writes_rd && rd_nonzero;
    end

    // Execute relies on these for forwarding and memory requests
    a_rd_we_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
        valid && ctrl.rd_we |-> fields.rd_idx != '0)
        else $error("rd_we set for x0");

    a_mem_op_encoding: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> ctrl.mem_op != decode_ctrl_pkg::mem_op_e'(2'b11))
        else $error("unused mem_op encoding");

endmodule : ctrl_decoder

//--- source/decode_stage.sv
// Single-cycle RV32I decode; register file must answer combinationally, no CSR or SYSTEM support
module decode_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              d_stall,
    input  logic                              d_flush,
    input  logic                              f2_to_d_valid,
    input  decode_ctrl_pkg::fetch_to_decode_s f2_to_d,
    output riscv_isa_pkg::reg_idx_t           rf_rs1_idx,
    output riscv_isa_pkg::reg_idx_t           rf_rs2_idx,
    input  riscv_isa_pkg::word_t              rf_rs1_val,
    input  riscv_isa_pkg::word_t              rf_rs2_val,
    output logic                              d_to_e_valid,
    output decode_ctrl_pkg::decode_to_exec_s  d_to_e
);

    decode_ctrl_pkg::fetch_to_decode_s payload;
    riscv_isa_pkg::fields_s            fields;
    decode_ctrl_pkg::ctrl_s            ctrl;

    // Registered fetch item, held under stall
    decode_input_reg decode_input_reg_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (d_stall),
        .flush      (d_flush),
        .in_valid   (f2_to_d_valid),
        .in_payload (f2_to_d),
        .payload    (payload),
        .out_valid  (d_to_e_valid)
    );

    instr_field_extract instr_field_extract_inst (
        .instr  (payload.instr),
        .fields (fields)
    );

    ctrl_decoder ctrl_decoder_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .valid  (d_to_e_valid),
        .fields (fields),
        .ctrl   (ctrl)
    );

    // Register file read, values come back in the same cycle
    assign rf_rs1_idx = fields.rs1_idx;
    assign rf_rs2_idx = fields.rs2_idx;

    assign d_to_e = '{
        pc:        payload.pc,
        rd_idx:    fields.rd_idx,
        rs1_idx:   fields.rs1_idx,
        rs2_idx:   fields.rs2_idx,
        rs1_val:   rf_rs1_val,
        rs2_val:   rf_rs2_val,
        immediate: fields.imm,
        ctrl:      ctrl
    };

endmodule : decode_stage

//--- testbench/decode_ref.svh
// Expected RV32I decode from the instruction word; covers only the opcodes the stage supports
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected stage output for one fetched item
function automatic decode_ctrl_pkg::decode_to_exec_s expected_decode(
    input riscv_isa_pkg::word_t  pc,
    input riscv_isa_pkg::instr_t instr,
    input riscv_isa_pkg::word_t  rs1_val,
    input riscv_isa_pkg::word_t  rs2_val
);
    decode_ctrl_pkg::decode_to_exec_s result;
    decode_ctrl_pkg::ctrl_s           c;
    decode_ctrl_pkg::alu_op_e         alu;
    logic [4:0]                       op;
    logic [2:0]                       f3;
    logic [11:0]                      i_off;
    logic [11:0]                      s_off;
    logic [12:0]                      b_off;
    logic [20:0]                      j_off;
    logic                             wr;

    op    = instr[6:2];
    f3    = instr[14:12];
    i_off = instr[31:20];
    s_off = {instr[31:25], instr[11:7]};
    b_off = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    j_off = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    result.pc      = pc;
    result.rd_idx  = instr[11:7];
    result.rs1_idx = instr[19:15];
    result.rs2_idx = instr[24:20];
    result.rs1_val = rs1_val;
    result.rs2_val = rs2_val;

    // Immediate follows the opcode's format
    case (op)
        riscv_isa_pkg::OPCODE_LOAD,
        riscv_isa_pkg::OPCODE_OP_IMM,
        riscv_isa_pkg::OPCODE_JALR:   result.immediate = {{20{i_off[11]}}, i_off};
        riscv_isa_pkg::OPCODE_STORE:  result.immediate = {{20{s_off[11]}}, s_off};
        riscv_isa_pkg::OPCODE_BRANCH: result.immediate = {{19{b_off[12]}}, b_off};
        riscv_isa_pkg::OPCODE_LUI,
        riscv_isa_pkg::OPCODE_AUIPC:  result.immediate = {instr[31:12], 12'h000};
        riscv_isa_pkg::OPCODE_JAL:    result.immediate = {{11{j_off[20]}}, j_off};
        default:                      result.immediate = '0;
    endcase

    // Integer op from funct3, bit 30 for SUB and SRA
    case (f3)
        3'b000: begin
            if (op == riscv_isa_pkg::OPCODE_OP && instr[30]) begin
                alu = decode_ctrl_pkg::ALU_OP_SUB;
            end else begin
                alu = decode_ctrl_pkg::ALU_OP_ADD;
            end
        end
        3'b001:  alu = decode_ctrl_pkg::ALU_OP_SLL;
        3'b010:  alu = decode_ctrl_pkg::ALU_OP_SLT;
        3'b011:  alu = decode_ctrl_pkg::ALU_OP_SLTU;
        3'b100:  alu = decode_ctrl_pkg::ALU_OP_XOR;
        3'b101:  alu = instr[30] ? decode_ctrl_pkg::ALU_OP_SRA : decode_ctrl_pkg::ALU_OP_SRL;
        3'b110:  alu = decode_ctrl_pkg::ALU_OP_OR;
        default: alu = decode_ctrl_pkg::ALU_OP_AND;
    endcase

    // All-zero control is RS1, RS2, ADD, ALU writeback, no memory, no branch
    c  = '0;
    wr = 1'b0;
    if (instr[1:0] != 2'b11) begin
        c.illegal_instr = 1'b1;
    end else begin
        case (op)
            riscv_isa_pkg::OPCODE_OP: begin
                wr       = 1'b1;
                c.alu_op = alu;
            end
            riscv_isa_pkg::OPCODE_OP_IMM: begin
                wr            = 1'b1;
                c.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
                c.alu_op      = alu;
            end
            riscv_isa_pkg::OPCODE_LOAD: begin
                wr            = 1'b1;
                c.rd_src      = decode_ctrl_pkg::RD_SRC_MEM;
                c.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
                c.mem_op      = decode_ctrl_pkg::MEM_OP_LOAD;
                c.mem_signed  = ~f3[2];
                c.mem_size    = decode_ctrl_pkg::mem_size_e'(f3[1:0]);
            end
            riscv_isa_pkg::OPCODE_STORE: begin
                c.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
                c.mem_op      = decode_ctrl_pkg::MEM_OP_STORE;
                c.mem_size    = decode_ctrl_pkg::mem_size_e'(f3[1:0]);
            end
            riscv_isa_pkg::OPCODE_BRANCH: begin
                c.branch = decode_ctrl_pkg::BRANCH_COND;
                c.cmp_op = decode_ctrl_pkg::cmp_op_e'(f3);
            end
            riscv_isa_pkg::OPCODE_JAL,
            riscv_isa_pkg::OPCODE_JALR: begin
                wr            = 1'b1;
                c.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_PC;
                c.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_FOUR;
                c.branch      = (op == riscv_isa_pkg::OPCODE_JAL) ? decode_ctrl_pkg::BRANCH_JAL
                                                                  : decode_ctrl_pkg::BRANCH_JALR;
            end
            riscv_isa_pkg::OPCODE_LUI: begin
                wr            = 1'b1;
                c.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_ZERO;
                c.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
            end
            riscv_isa_pkg::OPCODE_AUIPC: begin
                wr            = 1'b1;
                c.alu_op1_src = decode_ctrl_pkg::ALU_OP1_SRC_PC;
                c.alu_op2_src = decode_ctrl_pkg::ALU_OP2_SRC_IMM;
            end
            default: c.illegal_instr = 1'b1;
        endcase
    end
    // No write to x0
    c.rd_we     = wr && (instr[11:7] != 5'd0);
    result.ctrl = c;
    return result;
endfunction

`endif

//--- testbench/tb_decode_stage.sv
// Directed and random RV32I items with stall and flush; rf model is index-based, not a real file
module tb_decode_stage;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int N_DIRECTED   = 8;
    localparam int N_RANDOM     = 400;
    localparam int N_ITEMS      = N_DIRECTED + N_RANDOM;
    // Four cycles per item at most, plus reset
    localparam int TIMEOUT      = N_ITEMS * 4 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic                              clk;
    logic                              rst_n;
    logic                              d_stall;
    logic                              d_flush;
    logic                              f2_to_d_valid;
    decode_ctrl_pkg::fetch_to_decode_s f2_to_d;
    riscv_isa_pkg::reg_idx_t           rf_rs1_idx;
    riscv_isa_pkg::reg_idx_t           rf_rs2_idx;
    riscv_isa_pkg::word_t              rf_rs1_val;
    riscv_isa_pkg::word_t              rf_rs2_val;
    logic                              d_to_e_valid;
    decode_ctrl_pkg::decode_to_exec_s  d_to_e;

    // Expected items in fetch order, popped when the stage captures them
    decode_ctrl_pkg::decode_to_exec_s  expected_q[$];
    decode_ctrl_pkg::decode_to_exec_s  held_item;
    logic                              held_valid;
    integer                            seed = 41666;
    int                                sent_count;
    int                                flushed_count;
    int                                delivered_count;
    riscv_isa_pkg::word_t              next_pc;

    `include "decode_ref.svh"

    decode_stage decode_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .d_stall       (d_stall),
        .d_flush       (d_flush),
        .f2_to_d_valid (f2_to_d_valid),
        .f2_to_d       (f2_to_d),
        .rf_rs1_idx    (rf_rs1_idx),
        .rf_rs2_idx    (rf_rs2_idx),
        .rf_rs1_val    (rf_rs1_val),
        .rf_rs2_val    (rf_rs2_val),
        .d_to_e_valid  (d_to_e_valid),
        .d_to_e        (d_to_e)
    );

    // Register value from its index, distinct per register
    function automatic riscv_isa_pkg::word_t rf_value(input riscv_isa_pkg::reg_idx_t idx);
        return (32'(idx) * 32'h0101_0101) ^ 32'h5A3C_96E1;
    endfunction

    assign rf_rs1_val = rf_value(rf_rs1_idx);
    assign rf_rs2_val = rf_value(rf_rs2_idx);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_d_to_e(input decode_ctrl_pkg::decode_to_exec_s got,
                                input decode_ctrl_pkg::decode_to_exec_s exp);
        if (got !== exp) begin
            $display("ERROR at %0t: d_to_e is %h, expected %h (pc %h)", $time, got, exp, exp.pc);
            $display("tests failed");
            $fatal(1, "decode output mismatch");
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: d_to_e_valid is %b, expected %b", $time, got, exp);
            $display("tests failed");
            $fatal(1, "output valid mismatch");
        end
    endtask

    task automatic check_rf_idx(input riscv_isa_pkg::reg_idx_t got,
                                input riscv_isa_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: register file index is %0d, expected %0d", $time, got, exp);
            $display("tests failed");
            $fatal(1, "register index mismatch");
        end
    endtask

    // Mostly a legal opcode with random fields, else any 32-bit word
    function automatic riscv_isa_pkg::instr_t random_instr();
        riscv_isa_pkg::instr_t word;
        logic [31:0]           pick;
        riscv_isa_pkg::opcode_e op;
        word = $random(seed);
        pick = $random(seed);
        if (pick[2:0] == 3'd0) begin
            return word;
        end
        case (pick[31:4] % 9)
            0:       op = riscv_isa_pkg::OPCODE_LOAD;
            1:       op = riscv_isa_pkg::OPCODE_OP_IMM;
            2:       op = riscv_isa_pkg::OPCODE_AUIPC;
            3:       op = riscv_isa_pkg::OPCODE_STORE;
            4:       op = riscv_isa_pkg::OPCODE_OP;
            5:       op = riscv_isa_pkg::OPCODE_LUI;
            6:       op = riscv_isa_pkg::OPCODE_BRANCH;
            7:       op = riscv_isa_pkg::OPCODE_JALR;
            default: op = riscv_isa_pkg::OPCODE_JAL;
        endcase
        return {word[31:7], op, 2'b11};
    endfunction

    // One valid item per call, seen by the DUT on the next edge
    task automatic present(input riscv_isa_pkg::instr_t instr);
        @(posedge clk);
        f2_to_d_valid <= 1'b1;
        f2_to_d       <= '{pc: next_pc, instr: instr};
        d_stall       <= 1'b0;
        d_flush       <= 1'b0;
        expected_q.push_back(expected_decode(next_pc, instr,
                                             rf_value(instr[19:15]), rf_value(instr[24:20])));
        sent_count++;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            f2_to_d_valid <= 1'b0;
            d_stall       <= 1'b0;
            d_flush       <= 1'b0;
        end
    endtask

    // Fresh junk payload each stalled cycle, so a missed hold shows on d_to_e
    task automatic stall_for(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            f2_to_d_valid <= 1'b0;
            f2_to_d       <= {$random(seed), $random(seed)};
            d_stall       <= 1'b1;
            d_flush       <= 1'b0;
        end
    endtask

    // Only right after present, so it always kills a real item
    task automatic flush_held();
        @(posedge clk);
        f2_to_d_valid <= 1'b0;
        d_stall       <= 1'b0;
        d_flush       <= 1'b1;
        flushed_count++;
    endtask

    // Stimulus
    initial begin
        logic [31:0] action;
        rst_n           = 1'b0;
        d_stall         = 1'b0;
        d_flush         = 1'b0;
        f2_to_d_valid   = 1'b0;
        f2_to_d         = '0;
        next_pc         = 32'h0000_1000;
        sent_count      = 0;
        flushed_count   = 0;
        delivered_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        idle(4);

        // add x3,x1,x2 then held through a stall
        present(32'h0020_81B3);
        stall_for(3);
        // add x0 and addi x0 drop rd_we
        present(32'h0020_8033);
        present(32'h0000_0013);
        // SYSTEM, AMO, MISC_MEM
        present(32'h0000_0073);
        present(32'h0000_202F);
        present(32'h0000_000F);
        // addi with low bits 01, then flushed
        present(32'h00A0_0091);
        flush_held();
        // Opcode outside RV32I
        present(32'h0000_007F);

        for (int i = 0; i < N_RANDOM; i++) begin
            present(random_instr());
            action = $random(seed);
            case (action[2:0])
                3'd5:    stall_for(1 + action[3]);
                3'd6:    flush_held();
                3'd7:    idle(1);
                default: ;
            endcase
        end
        idle(3);

        if (delivered_count == sent_count - flushed_count && expected_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("Item count wrong: %0d delivered, %0d sent, %0d flushed, %0d still queued",
                     delivered_count, sent_count, flushed_count, expected_q.size());
            $display("tests failed");
            $fatal(1, "item count mismatch");
        end
    end

    // Compare: track the captured item at the edge, check at the falling edge
    initial begin
        logic exp_valid;
        held_valid = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                held_valid = 1'b0;
            end else if (!d_stall) begin
                held_valid = f2_to_d_valid;
                if (f2_to_d_valid) begin
                    if (expected_q.size() == 0) begin
                        $display("The stage captured an item that was never sent");
                        $display("tests failed");
                        $fatal(1, "no expected item");
                    end
                    held_item = expected_q.pop_front();
                end
            end
            @(negedge clk);
            if (rst_n) begin
                exp_valid = held_valid && !d_stall && !d_flush;
                check_valid(d_to_e_valid, exp_valid);
                // Held item stays on the outputs under stall and flush too
                if (held_valid) begin
                    check_d_to_e(d_to_e, held_item);
                    check_rf_idx(rf_rs1_idx, held_item.rs1_idx);
                    check_rf_idx(rf_rs2_idx, held_item.rs2_idx);
                end
                if (exp_valid) begin
                    delivered_count++;
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("The run timed out at %0t before the stimulus finished", $time);
        $display("tests failed");
        $fatal(1, "timeout");
    end

endmodule : tb_decode_stage

//--- project.f
+incdir+testbench
source/riscv_isa_pkg.sv
source/decode_ctrl_pkg.sv
source/decode_input_reg.sv
source/instr_field_extract.sv
source/ctrl_decoder.sv
source/decode_stage.sv
testbench/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - source/riscv_isa_pkg.sv
      - source/decode_ctrl_pkg.sv
      - source/decode_input_reg.sv
      - source/instr_field_extract.sv
      - source/ctrl_decoder.sv
      - source/decode_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_decode_stage.sv
